/* design/ebox_params.svh */
`ifndef EBOX_PARAMS_SVH
`define EBOX_PARAMS_SVH

// Data path
`define EBOX_WORD_W 36          // Bits 0..35, numbered from the left
`define MAGIC_W     9           // Zero-extended into a word

// Control RAM
`define CRAM_AW     8
`define CRAM_DEPTH  (1 << `CRAM_AW)

// Microcode return stack
`define CALL_DEPTH  4

// Diagnostic read selects on EBUS
`define DIAG_SEL_NONE  2'd0
`define DIAG_SEL_AR    2'd1     // EDP
`define DIAG_SEL_BR    2'd2     // EDP
`define DIAG_SEL_CRADR 2'd3     // CRA

`endif

/* design/eboxPkg.sv */
`include "ebox_params.svh"

package eboxPkg;

  typedef logic [0:`EBOX_WORD_W-1] word36T;
  typedef logic [0:`CRAM_AW-1]     cramAdrT;

  typedef enum logic [2:0] {
    adfA,
    adfB,
    adfAdd,
    adfSub,                      // A minus B
    adfAnd,
    adfOr,
    adfXor,
    adfZero
  } adFuncT;

  typedef enum logic {
    adbBr,
    adbMagic
  } adbSelT;

  typedef enum logic [1:0] {
    arHold,
    arAd,
    arMem                        // Loaded by the memory port only
  } arSelT;

  typedef enum logic [1:0] {
    skipNone,
    skipAdEq0,
    skipAdNeg,
    skipAlways
  } skipCondT;

  typedef enum logic [1:0] {
    memNone,
    memRead,
    memWrite
  } memOpT;

  typedef enum logic [1:0] {
    diagNone  = `DIAG_SEL_NONE,
    diagAr    = `DIAG_SEL_AR,
    diagBr    = `DIAG_SEL_BR,
    diagCradr = `DIAG_SEL_CRADR
  } diagSelT;

  // One microword, J in the top bits
  typedef struct packed {
    cramAdrT             j;
    adFuncT              adFunc;
    logic                adaZero;  // A is zero instead of AR
    adbSelT              adbSel;
    arSelT               arSel;
    logic                brLoad;   // BR gets AD
    logic [0:`MAGIC_W-1] magic;
    skipCondT            skip;
    logic                call;
    logic                ret;
    memOpT               mem;
    logic                halt;
  } cramWordT;

endpackage

/* design/crmStore.sv */
`include "ebox_params.svh"

module crmStore (
  input  logic              eboxClk,
  input  logic              rst,
  input  logic              cramWe,
  input  eboxPkg::cramAdrT  cramLoadAdr,
  input  eboxPkg::cramWordT cramLoadData,
  input  eboxPkg::cramAdrT  nextAdr,
  input  logic              advance,
  output eboxPkg::cramWordT cramWord
);
  import eboxPkg::*;

  cramWordT cram [`CRAM_DEPTH];

  // Load port, used only while the sequencer is stopped
  always_ff @(posedge eboxClk) begin
    if (cramWe) begin
      cram[cramLoadAdr] <= cramLoadData;
    end
  end

  // Registered read. Holding advance low keeps a stalled word in place
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      cramWord <= '0;                 // All-zero word does nothing
    end else if (advance) begin
      cramWord <= cram[nextAdr];
    end
  end

  // A write during execution would race the read of the next word
  noLoadWhileRunning: assert property (
    @(posedge eboxClk) disable iff (rst)
    cramWe |-> !advance
  ) else $error("CRAM written while the sequencer advances");

endmodule

/* design/craSequencer.sv */
`include "ebox_params.svh"

module craSequencer (
  input  logic              eboxClk,
  input  logic              rst,
  input  logic              start,
  input  eboxPkg::cramWordT cramWord,
  input  logic              adZero,
  input  logic              adNeg,
  input  logic              memDone,
  input  eboxPkg::diagSelT  diagSel,
  input  logic              diagRead,
  output eboxPkg::cramAdrT  nextAdr,
  output logic              advance,
  output logic              memStart,
  output logic              running,
  output logic              craDrivingEbus,
  output eboxPkg::word36T   craEbus
);
  import eboxPkg::*;

  localparam int SpW  = $clog2(`CALL_DEPTH + 1);
  localparam int PtrW = $clog2(`CALL_DEPTH);

  cramAdrT        cradr;                   // Address of the word in cramWord
  cramAdrT        callStack [`CALL_DEPTH];
  logic [SpW-1:0] sp;                      // Entries in use
  logic [PtrW-1:0] topIdx;
  logic           memWait;
  diagSelT        diagSelQ;
  logic           memWord;
  logic           stepping;
  logic           skipTaken;
  cramAdrT        baseAdr;
  cramAdrT        pushAdr;

  assign memWord  = (cramWord.mem != memNone);
  assign memStart = running && memWord && !memWait;
  assign stepping = running && (!memWord || memDone);  // Word completes this cycle
  assign advance  = start || stepping;

  always_comb begin
    case (cramWord.skip)
      skipAdEq0:  skipTaken = adZero;
      skipAdNeg:  skipTaken = adNeg;
      skipAlways: skipTaken = 1'b1;
      default:    skipTaken = 1'b0;
    endcase
  end

  assign topIdx  = sp[PtrW-1:0] - 1'b1;
  assign pushAdr = cradr + 1'b1;
  assign baseAdr = cramWord.ret ? callStack[topIdx] : cramWord.j;

  always_comb begin
    if (start) begin
      nextAdr = '0;
    end else if (cramWord.halt) begin
      nextAdr = cradr;                     // Halt word re-reads itself
    end else begin
      nextAdr = baseAdr | cramAdrT'(skipTaken);  // Skip ORs into the low bit
    end
  end

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      running  <= 1'b0;
      cradr    <= '0;
      sp       <= '0;
      memWait  <= 1'b0;
      diagSelQ <= diagNone;
    end else begin
      diagSelQ <= diagSel;
      if (advance) begin
        cradr <= nextAdr;
      end
      if (start) begin
        running <= 1'b1;
        sp      <= '0;
      end else if (stepping) begin
        if (cramWord.halt) begin
          running <= 1'b0;
        end
        case ({cramWord.call, cramWord.ret})
          2'b10:   sp <= sp + 1'b1;
          2'b01:   sp <= sp - 1'b1;
          default: sp <= sp;               // Call plus return replaces the top
        endcase
      end
      if (memStart) begin
        memWait <= 1'b1;
      end else if (memDone) begin
        memWait <= 1'b0;
      end
    end
  end

  // Return addresses
  always_ff @(posedge eboxClk) begin
    if (!start && stepping && cramWord.call) begin
      callStack[cramWord.ret ? topIdx : sp[PtrW-1:0]] <= pushAdr;
    end
  end

  assign craDrivingEbus = diagRead && (diagSelQ == diagCradr);
  assign craEbus        = craDrivingEbus ? word36T'(cradr) : '0;

  pushNotFull: assert property (
    @(posedge eboxClk) disable iff (rst)
    !start && stepping && cramWord.call && !cramWord.ret |-> sp < `CALL_DEPTH
  ) else $error("Call with the return stack full");

  popNotEmpty: assert property (
    @(posedge eboxClk) disable iff (rst)
    !start && stepping && cramWord.ret |-> sp != '0
  ) else $error("Return with the return stack empty");

  // One request per memory word, however long the MBOX takes
  memStartPulse: assert property (
    @(posedge eboxClk) disable iff (rst)
    memStart |=> !memStart
  ) else $error("memStart held for more than one cycle");

endmodule

/* design/edpDatapath.sv */
module edpDatapath (
  input  logic              eboxClk,
  input  logic              rst,
  input  eboxPkg::cramWordT cramWord,
  input  logic              advance,
  input  logic              memLoad,
  input  eboxPkg::word36T   cacheDataRead,
  input  eboxPkg::diagSelT  diagSel,
  input  logic              diagRead,
  output eboxPkg::word36T   ad,
  output logic              adZero,
  output logic              adNeg,
  output eboxPkg::word36T   ar,
  output logic              edpDrivingEbus,
  output eboxPkg::word36T   edpEbus
);
  import eboxPkg::*;

  word36T  br;
  word36T  adA;
  word36T  adB;
  word36T  magicWord;
  logic    execute;
  diagSelT diagSelQ;

  assign magicWord = word36T'(cramWord.magic);
  assign adA = cramWord.adaZero ? '0 : ar;
  assign adB = (cramWord.adbSel == adbMagic) ? magicWord : br;

  // AD function unit, wraps at 36 bits
  always_comb begin
    case (cramWord.adFunc)
      adfA:    ad = adA;
      adfB:    ad = adB;
      adfAdd:  ad = adA + adB;
      adfSub:  ad = adA - adB;
      adfAnd:  ad = adA & adB;
      adfOr:   ad = adA | adB;
      adfXor:  ad = adA ^ adB;
      default: ad = '0;
    endcase
  end

  assign adZero = (ad == '0);
  assign adNeg  = ad[0];              // Sign is the leftmost bit

  // A halt word does no register work, so a restart that presents it
  // again during the start cycle leaves AR and BR alone
  assign execute = advance && !cramWord.halt;

  always_ff @(posedge eboxClk) begin
    if (memLoad) begin
      ar <= cacheDataRead;            // Read data from the MBOX
    end else if (execute && (cramWord.arSel == arAd)) begin
      ar <= ad;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (execute && cramWord.brLoad) begin
      br <= ad;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      diagSelQ <= diagNone;
    end else begin
      diagSelQ <= diagSel;
    end
  end

  assign edpDrivingEbus = diagRead && ((diagSelQ == diagAr) || (diagSelQ == diagBr));

  always_comb begin
    if (!edpDrivingEbus) begin
      edpEbus = '0;
    end else if (diagSelQ == diagAr) begin
      edpEbus = ar;
    end else begin
      edpEbus = br;
    end
  end

  // Read data arrives only while the sequencer is stalled
  memLoadInStall: assert property (
    @(posedge eboxClk) disable iff (rst)
    memLoad |-> !advance
  ) else $error("Memory load collides with a microword step");

endmodule

/* design/mboxPort.sv */
module mboxPort (
  input  logic            eboxClk,
  input  logic            rst,
  input  logic            memStart,
  input  eboxPkg::memOpT  memOp,
  input  eboxPkg::word36T ad,
  input  eboxPkg::word36T ar,
  input  logic            mboxResp,
  output logic            eboxReq,
  output logic            eboxWrite,
  output eboxPkg::word36T eboxVma,
  output eboxPkg::word36T cacheDataWrite,
  output logic            memLoad,
  output logic            memDone
);
  import eboxPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stReq,                            // eboxReq up, waiting for mboxResp
    stRelease,                        // eboxReq down, waiting for mboxResp to fall
    stDone
  } mboxStateT;

  mboxStateT state;
  logic      isWrite;

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      state   <= stIdle;
      isWrite <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (memStart) begin
            state   <= stReq;
            isWrite <= (memOp == memWrite);
          end
        end
        stReq: begin
          if (mboxResp) begin
            state <= stRelease;
          end
        end
        stRelease: begin
          if (!mboxResp) begin
            state <= stDone;
          end
        end
        default: state <= stIdle;      // Done lasts one cycle
      endcase
    end
  end

  // Address and write data
  always_ff @(posedge eboxClk) begin
    if ((state == stIdle) && memStart) begin
      eboxVma        <= ad;
      cacheDataWrite <= ar;
    end
  end

  assign eboxReq   = (state == stReq);
  assign eboxWrite = eboxReq && isWrite;
  assign memLoad   = eboxReq && mboxResp && !isWrite;
  assign memDone   = (state == stDone);

  // The MBOX answers only a request that is still up
  reqHeldUntilResp: assert property (
    @(posedge eboxClk) disable iff (rst)
    $rose(mboxResp) |-> eboxReq
  ) else $error("mboxResp rose without eboxReq");

endmodule

/* design/ebox.sv */
module ebox (
  input  logic              eboxClk,
  input  logic              rst,
  input  logic              start,
  input  logic              cramWe,
  input  eboxPkg::cramAdrT  cramLoadAdr,
  input  eboxPkg::cramWordT cramLoadData,
  input  eboxPkg::word36T   cacheDataRead,
  input  logic              mboxResp,
  input  eboxPkg::diagSelT  diagSel,
  input  logic              diagRead,
  output logic              running,
  output logic              eboxReq,
  output logic              eboxWrite,
  output eboxPkg::word36T   eboxVma,
  output eboxPkg::word36T   cacheDataWrite,
  output logic              edpDrivingEbus,
  output eboxPkg::word36T   edpEbus,
  output logic              craDrivingEbus,
  output eboxPkg::word36T   craEbus
);
  import eboxPkg::*;

  cramWordT cramWord;
  cramAdrT  nextAdr;
  logic     advance;                  // Current microword completes
  logic     memStart;
  logic     memDone;
  logic     memLoad;
  logic     adZero;
  logic     adNeg;
  word36T   ad;
  word36T   ar;

  crmStore crm0 (
    .eboxClk      (eboxClk),
    .rst          (rst),
    .cramWe       (cramWe),
    .cramLoadAdr  (cramLoadAdr),
    .cramLoadData (cramLoadData),
    .nextAdr      (nextAdr),
    .advance      (advance),
    .cramWord     (cramWord)
  );

  craSequencer cra0 (
    .eboxClk        (eboxClk),
    .rst            (rst),
    .start          (start),
    .cramWord       (cramWord),
    .adZero         (adZero),
    .adNeg          (adNeg),
    .memDone        (memDone),
    .diagSel        (diagSel),
    .diagRead       (diagRead),
    .nextAdr        (nextAdr),
    .advance        (advance),
    .memStart       (memStart),
    .running        (running),
    .craDrivingEbus (craDrivingEbus),
    .craEbus        (craEbus)
  );

  edpDatapath edp0 (
    .eboxClk        (eboxClk),
    .rst            (rst),
    .cramWord       (cramWord),
    .advance        (advance),
    .memLoad        (memLoad),
    .cacheDataRead  (cacheDataRead),
    .diagSel        (diagSel),
    .diagRead       (diagRead),
    .ad             (ad),
    .adZero         (adZero),
    .adNeg          (adNeg),
    .ar             (ar),
    .edpDrivingEbus (edpDrivingEbus),
    .edpEbus        (edpEbus)
  );

  mboxPort mbox0 (
    .eboxClk        (eboxClk),
    .rst            (rst),
    .memStart       (memStart),
    .memOp          (cramWord.mem),
    .ad             (ad),
    .ar             (ar),
    .mboxResp       (mboxResp),
    .eboxReq        (eboxReq),
    .eboxWrite      (eboxWrite),
    .eboxVma        (eboxVma),
    .cacheDataWrite (cacheDataWrite),
    .memLoad        (memLoad),
    .memDone        (memDone)
  );

endmodule

/* tests/eboxTb.sv */
module eboxTb;
  import eboxPkg::*;

  logic     eboxClk = 1'b0;
  logic     rst;
  logic     start, cramWe, mboxResp, diagRead;
  cramAdrT  cramLoadAdr;
  cramWordT cramLoadData;
  word36T   cacheDataRead;
  diagSelT  diagSel;
  logic     running, eboxReq, eboxWrite, edpDrivingEbus, craDrivingEbus;
  word36T   eboxVma, cacheDataWrite, edpEbus, craEbus;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr = 32'h7059_264c;
  word36T      memModel [256];              // MBOX memory, low 8 VMA bits
  cramWordT    prog [256];                  // Image for the next CRAM load

  ebox u_dut (.*);

  always #5 eboxClk = ~eboxClk;

  // Galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [35:0] v);
    v = '0;
    repeat (n) begin
      v = {v[34:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
  endtask

  function automatic word36T fillWord(input logic [7:0] a);
    return {4'h5, a, ~a, a ^ 8'h3c, ~a ^ 8'hc3};
  endfunction

  // AD function rules, 36-bit wrap
  function automatic logic [35:0] adRule(input adFuncT f, input logic [35:0] a,
                                         input logic [35:0] b);
    case (f)
      adfA:    return a;
      adfB:    return b;
      adfAdd:  return a + b;
      adfSub:  return a - b;
      adfAnd:  return a & b;
      adfOr:   return a | b;
      adfXor:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic cramWordT mk(input cramAdrT j, input adFuncT f, input adbSelT bs,
                                  input arSelT as, input logic bl, input logic [8:0] m);
    cramWordT w;
    w        = '0;
    w.j      = j;
    w.adFunc = f;
    w.adbSel = bs;
    w.arSel  = as;
    w.brLoad = bl;
    w.magic  = m;
    return w;
  endfunction

  task automatic check(input string name, input logic [35:0] expected,
                       input logic [35:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s, stopped after %0d checks with %0d errors", why, checks, errors);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic clearProg();
    foreach (prog[i]) begin
      prog[i]      = '0;
      prog[i].halt = 1'b1;                  // Unused words stop the machine
    end
  endtask

  task automatic loadProgram(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge eboxClk);
      cramWe       <= 1'b1;
      cramLoadAdr  <= cramAdrT'(i);
      cramLoadData <= prog[i];
    end
    @(posedge eboxClk);
    cramWe <= 1'b0;
    clearProg();
  endtask

  task automatic runUntilHalt();
    int waited;
    @(posedge eboxClk);
    start <= 1'b1;
    @(posedge eboxClk);
    start  <= 1'b0;
    waited = 0;
    do begin
      @(posedge eboxClk);
      waited++;
    end while (running && waited < 2000);
    if (running) begin
      abortRun("Microcode did not reach a halt word");
    end
  endtask

  // Select is registered in each unit, so the data shows a cycle later
  task automatic readDiag(input diagSelT sel, input string name, input logic [35:0] expected);
    @(posedge eboxClk);
    diagSel  <= sel;
    diagRead <= 1'b1;
    @(posedge eboxClk);
    @(negedge eboxClk);
    check({name, " driving"}, 36'd1, (sel == diagCradr) ? craDrivingEbus : edpDrivingEbus);
    check({name, " other unit"}, 36'd0, (sel == diagCradr) ? edpDrivingEbus : craDrivingEbus);
    check(name, expected, (sel == diagCradr) ? craEbus : edpEbus);
    @(posedge eboxClk);
    diagRead <= 1'b0;
    diagSel  <= diagNone;
  endtask

  // MBOX model, answers after 0 to 7 cycles, releases once eboxReq falls
  always begin : responder
    logic [35:0] delay;
    int          waited;
    @(posedge eboxClk);
    if (eboxReq && !mboxResp) begin
      randomBits(3, delay);
      repeat (delay) @(posedge eboxClk);
      if (eboxWrite) begin
        memModel[eboxVma[28:35]] = cacheDataWrite;
      end
      cacheDataRead <= memModel[eboxVma[28:35]];
      mboxResp      <= 1'b1;
      waited = 0;
      do begin
        @(posedge eboxClk);
        waited++;
      end while (eboxReq && waited < 50);
      if (eboxReq) begin
        abortRun("eboxReq stayed high after mboxResp");
      end else begin
        mboxResp <= 1'b0;
      end
    end
  end

  task automatic arithTest();
    logic [35:0] a;
    logic [35:0] b;
    for (int f = 0; f < 8; f++) begin
      randomBits(9, a);
      randomBits(9, b);
      prog[0] = mk(1, adfB, adbMagic, arHold, 1'b1, b[8:0]);    // BR from magic
      prog[1] = mk(2, adfB, adbMagic, arAd, 1'b0, a[8:0]);
      prog[2] = mk(3, adFuncT'(f), adbBr, arAd, 1'b0, '0);
      loadProgram(4);
      runUntilHalt();
      readDiag(diagAr, "AR", adRule(adFuncT'(f), a, b));
      readDiag(diagBr, "BR", b);
      readDiag(diagCradr, "CRADR", 36'd3);
    end
  endtask

  // Word 0 tests 0 - m and jumps to 2, or to 3 on skip
  task automatic skipRun(input skipCondT c, input logic [8:0] m);
    logic [35:0] neg;
    logic        taken;
    neg   = 36'd0 - 36'(m);
    taken = (c == skipAdEq0) ? (neg == '0) : neg[35];
    prog[0]         = mk(2, adfSub, adbMagic, arHold, 1'b0, m);
    prog[0].adaZero = 1'b1;
    prog[0].skip    = c;
    prog[2] = mk(8'hc4, adfB, adbMagic, arAd, 1'b0, 9'h0a5);
    prog[3] = mk(8'hc4, adfB, adbMagic, arAd, 1'b0, 9'h15a);
    loadProgram('hc5);
    runUntilHalt();
    readDiag(diagAr, "AR after skip", taken ? 36'h15a : 36'h0a5);
    readDiag(diagCradr, "CRADR", 36'hc4);   // Halt far from the start
  endtask

  task automatic skipTest();
    logic [35:0] r;
    randomBits(9, r);
    skipRun(skipAdEq0, 9'd0);
    skipRun(skipAdEq0, r[8:0] | 9'd1);
    skipRun(skipAdNeg, r[8:0] | 9'd1);
    skipRun(skipAdNeg, 9'd0);
  endtask

  task automatic callTest();
    logic [35:0] m [5];
    for (int i = 0; i < 5; i++) begin
      randomBits(9, m[i]);
    end
    prog[0]       = mk(1, adfB, adbMagic, arAd, 1'b0, m[0][8:0]);
    prog[1]       = mk(10, adfA, adbBr, arHold, 1'b0, '0);
    prog[1].call  = 1'b1;                   // Returns to 2
    prog[2]       = mk(3, adfAdd, adbMagic, arAd, 1'b0, m[3][8:0]);
    prog[10]      = mk(20, adfAdd, adbMagic, arAd, 1'b0, m[1][8:0]);
    prog[10].call = 1'b1;                   // Returns to 11
    prog[11]      = mk(0, adfAdd, adbMagic, arAd, 1'b0, m[4][8:0]);
    prog[11].ret  = 1'b1;
    prog[20]      = mk(0, adfAdd, adbMagic, arAd, 1'b0, m[2][8:0]);
    prog[20].ret  = 1'b1;
    loadProgram(21);
    runUntilHalt();
    readDiag(diagAr, "AR after calls", m[0] + m[1] + m[2] + m[3] + m[4]);
    readDiag(diagCradr, "CRADR", 36'd3);
  endtask

  task automatic memoryTest();
    logic [35:0] a;
    logic [35:0] d;
    for (int k = 0; k < 4; k++) begin
      randomBits(9, a);
      randomBits(9, d);
      a[7] = 1'b0;                          // Second read address stays unwritten
      prog[0]     = mk(1, adfB, adbMagic, arAd, 1'b0, d[8:0]);
      prog[1]     = mk(2, adfB, adbMagic, arHold, 1'b0, a[8:0]);
      prog[1].mem = memWrite;
      prog[2]     = mk(3, adfZero, adbBr, arAd, 1'b0, '0);
      prog[3]     = mk(4, adfB, adbMagic, arHold, 1'b0, a[8:0]);
      prog[3].mem = memRead;
      prog[4]     = mk(5, adfA, adbBr, arHold, 1'b1, '0);     // BR keeps the read word
      prog[5]     = mk(6, adfB, adbMagic, arHold, 1'b0, a[8:0] | 9'h080);
      prog[5].mem = memRead;
      loadProgram(7);
      runUntilHalt();
      check("written word", d, memModel[a[7:0]]);
      check("eboxVma", 36'(a[8:0] | 9'h080), eboxVma);     // Last request address
      check("cacheDataWrite", d, cacheDataWrite);          // AR at the last request
      readDiag(diagBr, "BR after read", d);
      readDiag(diagAr, "AR after read", fillWord(a[7:0] | 8'h80));
    end
  endtask

  initial begin
    rst           = 1'b1;
    start         = 1'b0;
    cramWe        = 1'b0;
    cramLoadAdr   = '0;
    cramLoadData  = '0;
    cacheDataRead = '0;
    mboxResp      = 1'b0;
    diagSel       = diagNone;
    diagRead      = 1'b0;
    foreach (memModel[i]) begin
      memModel[i] = fillWord(8'(i));
    end
    clearProg();
    repeat (16) @(posedge eboxClk);
    rst <= 1'b0;
    @(negedge eboxClk);
    check("running", 36'd0, running);
    check("eboxReq", 36'd0, eboxReq);
    check("edpDrivingEbus", 36'd0, edpDrivingEbus);
    check("craDrivingEbus", 36'd0, craDrivingEbus);
    arithTest();
    skipTest();
    callTest();
    memoryTest();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/eboxPkg.sv
design/crmStore.sv
design/craSequencer.sv
design/edpDatapath.sv
design/mboxPort.sv
design/ebox.sv
tests/eboxTb.sv
